/* hw/rv_slice_cfg.svh */
`ifndef RV_SLICE_CFG_SVH
`define RV_SLICE_CFG_SVH

// data and pc width
`define XLEN      64
`define INSN_W    32
`define REG_IDX_W 5
`define WORD_W    32 // low word used by the W forms

`endif

/* hw/rv_slice_pkg.sv */
package rv_slice_pkg;

   // major opcodes
   localparam logic [6:0] OPC_OP        = 7'h33;
   localparam logic [6:0] OPC_OP_IMM    = 7'h13;
   localparam logic [6:0] OPC_OP_32     = 7'h3b;
   localparam logic [6:0] OPC_OP_IMM_32 = 7'h1b;
   localparam logic [6:0] OPC_LUI       = 7'h37;
   localparam logic [6:0] OPC_AUIPC     = 7'h17;
   localparam logic [6:0] OPC_BRANCH    = 7'h63;
   localparam logic [6:0] OPC_JAL       = 7'h6f;
   localparam logic [6:0] OPC_JALR      = 7'h67;

   // funct3 for OP / OP-IMM and their word forms
   localparam logic [2:0] F3_ADD_SUB = 3'd0;
   localparam logic [2:0] F3_SLL     = 3'd1;
   localparam logic [2:0] F3_SLT     = 3'd2;
   localparam logic [2:0] F3_SLTU    = 3'd3;
   localparam logic [2:0] F3_XOR     = 3'd4;
   localparam logic [2:0] F3_SRL_SRA = 3'd5;
   localparam logic [2:0] F3_OR      = 3'd6;
   localparam logic [2:0] F3_AND     = 3'd7;

   // funct3 for conditional branches
   localparam logic [2:0] F3_BEQ  = 3'd0;
   localparam logic [2:0] F3_BNE  = 3'd1;
   localparam logic [2:0] F3_BLT  = 3'd4;
   localparam logic [2:0] F3_BGE  = 3'd5;
   localparam logic [2:0] F3_BLTU = 3'd6;
   localparam logic [2:0] F3_BGEU = 3'd7;

   localparam logic [2:0] F3_JALR = 3'd0;

   // funct7, and the 6-bit form for 64-bit immediate shifts
   localparam logic [6:0] F7_BASE = 7'h00;
   localparam logic [6:0] F7_ALT  = 7'h20; // sub, sra
   localparam logic [5:0] F6_BASE = 6'h00;
   localparam logic [5:0] F6_ALT  = 6'h10;

   typedef enum logic [4:0] {
      ADD,
      SUB,
      SLL,
      SLT,
      SLTU,
      XOR,
      SRL,
      SRA,
      OR,
      AND,
      ADDW,
      SUBW,
      SLLW,
      SRLW,
      SRAW,
      BEQ,
      BNE,
      BLT,
      BGE,
      BLTU,
      BGEU,
      JAL,
      JALR,
      PASS_B, // lui
      ILLEGAL
   } alu_op_t;

endpackage

/* hw/issue_if.sv */
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

// four-phase req/ack link from decode to execute
interface issue_if;
   logic                     req;
   logic                     ack;
   rv_slice_pkg::alu_op_t    op;
   logic [`XLEN-1:0]         opa;
   logic [`XLEN-1:0]         opb;
   logic [`XLEN-1:0]         imm;   // branch / jump offset
   logic [`XLEN-1:0]         pc;
   logic [`REG_IDX_W-1:0]    rd;
   logic                     rd_we;

   modport decode_mp (
      output req, op, opa, opb, imm, pc, rd, rd_we,
      input  ack
   );

   modport exec_mp (
      input  req, op, opa, opb, imm, pc, rd, rd_we,
      output ack
   );
endinterface

/* hw/wb_if.sv */
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

// execute -> writeback link
interface wb_if;
   logic                     req;
   logic                     ack;
   logic [`REG_IDX_W-1:0]    rd;
   logic                     rd_we;
   logic [`XLEN-1:0]         rd_val;
   logic                     br_taken;
   logic [`XLEN-1:0]         next_pc;
   logic                     illegal;

   modport exec_mp (
      output req, rd, rd_we, rd_val, br_taken, next_pc, illegal,
      input  ack
   );

   modport wb_mp (
      input  req, rd, rd_we, rd_val, br_taken, next_pc, illegal,
      output ack
   );
endinterface

/* hw/insn_decode.sv */
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module insn_decode (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_req,
   output logic                  in_ack,
   input  logic [`INSN_W-1:0]    insn,
   input  logic [`XLEN-1:0]      pc,
   input  logic [`XLEN-1:0]      rs1_val,
   input  logic [`XLEN-1:0]      rs2_val,
   issue_if.decode_mp            iss
);

   logic                     full;
   logic [`INSN_W-1:0]       insn_q;
   logic [`XLEN-1:0]         pc_q;
   logic [`XLEN-1:0]         rs1_q;
   logic [`XLEN-1:0]         rs2_q;

   logic [6:0]               opcode;
   logic [2:0]               funct3;
   logic                     f7_base;
   logic                     f7_alt;
   logic                     f6_base;
   logic                     f6_alt;
   logic [`XLEN-1:0]         imm_i;
   logic [`XLEN-1:0]         imm_u;
   logic [`XLEN-1:0]         imm_b;
   logic [`XLEN-1:0]         imm_j;

   rv_slice_pkg::alu_op_t    op;
   logic [`XLEN-1:0]         imm;
   logic                     use_imm;
   logic                     use_pc;
   logic                     is_branch;

   wire take = in_req & ~in_ack & ~full;

   // ILLEGAL unless the extra funct bits check out
   function automatic rv_slice_pkg::alu_op_t pick(input logic ok,
                                                  input rv_slice_pkg::alu_op_t op_in);
      return ok ? op_in : rv_slice_pkg::ILLEGAL;
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         in_ack  <= 1'b0;
         full    <= 1'b0;
         iss.req <= 1'b0;
      end
      else
      begin
         if (take)
            in_ack <= 1'b1;
         else if (!in_req)
            in_ack <= 1'b0;

         if (take)
            full <= 1'b1;
         else if (iss.req && iss.ack)
            full <= 1'b0; // execute has it

         if (iss.req && iss.ack)
            iss.req <= 1'b0;
         else if (full && !iss.ack)
            iss.req <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         insn_q <= insn;
         pc_q   <= pc;
         rs1_q  <= rs1_val;
         rs2_q  <= rs2_val;
      end
   end

   assign opcode  = insn_q[6:0];
   assign funct3  = insn_q[14:12];
   assign f7_base = insn_q[31:25] == rv_slice_pkg::F7_BASE;
   assign f7_alt  = insn_q[31:25] == rv_slice_pkg::F7_ALT;
   assign f6_base = insn_q[31:26] == rv_slice_pkg::F6_BASE;
   assign f6_alt  = insn_q[31:26] == rv_slice_pkg::F6_ALT;

   assign imm_i = {{(`XLEN-12){insn_q[31]}}, insn_q[31:20]};
   assign imm_u = {{(`XLEN-32){insn_q[31]}}, insn_q[31:12], 12'd0};
   assign imm_b = {{(`XLEN-12){insn_q[31]}}, insn_q[7], insn_q[30:25], insn_q[11:8], 1'b0};
   assign imm_j = {{(`XLEN-20){insn_q[31]}}, insn_q[19:12], insn_q[20], insn_q[30:21], 1'b0};

   always_comb
   begin
      op        = rv_slice_pkg::ILLEGAL;
      imm       = imm_i;
      use_imm   = 1'b0;
      use_pc    = 1'b0;
      is_branch = 1'b0;
      case (opcode)
         rv_slice_pkg::OPC_OP:
         begin
            case (funct3)
               rv_slice_pkg::F3_ADD_SUB:
                  op = f7_alt ? rv_slice_pkg::SUB : pick(f7_base, rv_slice_pkg::ADD);
               rv_slice_pkg::F3_SLL:  op = pick(f7_base, rv_slice_pkg::SLL);
               rv_slice_pkg::F3_SLT:  op = pick(f7_base, rv_slice_pkg::SLT);
               rv_slice_pkg::F3_SLTU: op = pick(f7_base, rv_slice_pkg::SLTU);
               rv_slice_pkg::F3_XOR:  op = pick(f7_base, rv_slice_pkg::XOR);
               rv_slice_pkg::F3_SRL_SRA:
                  op = f7_alt ? rv_slice_pkg::SRA : pick(f7_base, rv_slice_pkg::SRL);
               rv_slice_pkg::F3_OR:   op = pick(f7_base, rv_slice_pkg::OR);
               default:               op = pick(f7_base, rv_slice_pkg::AND);
            endcase
         end
         rv_slice_pkg::OPC_OP_IMM:
         begin
            use_imm = 1'b1;
            case (funct3)
               rv_slice_pkg::F3_ADD_SUB: op = rv_slice_pkg::ADD;
               rv_slice_pkg::F3_SLL:     op = pick(f6_base, rv_slice_pkg::SLL);
               rv_slice_pkg::F3_SLT:     op = rv_slice_pkg::SLT;
               rv_slice_pkg::F3_SLTU:    op = rv_slice_pkg::SLTU;
               rv_slice_pkg::F3_XOR:     op = rv_slice_pkg::XOR;
               rv_slice_pkg::F3_SRL_SRA:
                  op = f6_alt ? rv_slice_pkg::SRA : pick(f6_base, rv_slice_pkg::SRL);
               rv_slice_pkg::F3_OR:      op = rv_slice_pkg::OR;
               default:                  op = rv_slice_pkg::AND;
            endcase
         end
         rv_slice_pkg::OPC_OP_32:
         begin
            case (funct3)
               rv_slice_pkg::F3_ADD_SUB:
                  op = f7_alt ? rv_slice_pkg::SUBW : pick(f7_base, rv_slice_pkg::ADDW);
               rv_slice_pkg::F3_SLL: op = pick(f7_base, rv_slice_pkg::SLLW);
               rv_slice_pkg::F3_SRL_SRA:
                  op = f7_alt ? rv_slice_pkg::SRAW : pick(f7_base, rv_slice_pkg::SRLW);
               default: ;
            endcase
         end
         rv_slice_pkg::OPC_OP_IMM_32:
         begin
            use_imm = 1'b1;
            case (funct3)
               rv_slice_pkg::F3_ADD_SUB: op = rv_slice_pkg::ADDW;
               rv_slice_pkg::F3_SLL:     op = pick(f7_base, rv_slice_pkg::SLLW);
               rv_slice_pkg::F3_SRL_SRA:
                  op = f7_alt ? rv_slice_pkg::SRAW : pick(f7_base, rv_slice_pkg::SRLW);
               default: ;
            endcase
         end
         rv_slice_pkg::OPC_LUI:
         begin
            op      = rv_slice_pkg::PASS_B;
            imm     = imm_u;
            use_imm = 1'b1;
         end
         rv_slice_pkg::OPC_AUIPC:
         begin
            op      = rv_slice_pkg::ADD; // pc + upper imm
            imm     = imm_u;
            use_imm = 1'b1;
            use_pc  = 1'b1;
         end
         rv_slice_pkg::OPC_BRANCH:
         begin
            imm       = imm_b;
            is_branch = 1'b1;
            case (funct3)
               rv_slice_pkg::F3_BEQ:  op = rv_slice_pkg::BEQ;
               rv_slice_pkg::F3_BNE:  op = rv_slice_pkg::BNE;
               rv_slice_pkg::F3_BLT:  op = rv_slice_pkg::BLT;
               rv_slice_pkg::F3_BGE:  op = rv_slice_pkg::BGE;
               rv_slice_pkg::F3_BLTU: op = rv_slice_pkg::BLTU;
               rv_slice_pkg::F3_BGEU: op = rv_slice_pkg::BGEU;
               default: ;
            endcase
         end
         rv_slice_pkg::OPC_JAL:
         begin
            op  = rv_slice_pkg::JAL;
            imm = imm_j;
         end
         rv_slice_pkg::OPC_JALR:
            op = pick(funct3 == rv_slice_pkg::F3_JALR, rv_slice_pkg::JALR);
         default: ;
      endcase
   end

   assign iss.op    = op;
   assign iss.opa   = use_pc ? pc_q : rs1_q;
   assign iss.opb   = use_imm ? imm : rs2_q;
   assign iss.imm   = imm;
   assign iss.pc    = pc_q;
   assign iss.rd    = insn_q[11:7];
   // x0 never written
   assign iss.rd_we = (insn_q[11:7] != '0) && !is_branch && (op != rv_slice_pkg::ILLEGAL);

endmodule

/* hw/int_execute.sv */
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module int_execute (
   input  logic      clk,
   input  logic      rst_n,
   issue_if.exec_mp  iss,
   wb_if.exec_mp     wb
);

   localparam int SH_W  = $clog2(`XLEN);
   localparam int WSH_W = $clog2(`WORD_W);
   localparam logic [`XLEN-1:0] INSN_BYTES = 4;

   logic                  full;
   logic [`XLEN-1:0]      alu;
   logic [`WORD_W-1:0]    wres;
   logic                  word_op;
   logic                  cond;
   logic [`XLEN-1:0]      npc;

   wire take = iss.req & ~iss.ack & ~full;

   wire [`XLEN-1:0]   a        = iss.opa;
   wire [`XLEN-1:0]   b        = iss.opb;
   wire [`WORD_W-1:0] w_a      = a[`WORD_W-1:0];
   wire [`WORD_W-1:0] w_b      = b[`WORD_W-1:0];
   wire [`XLEN-1:0]   link     = iss.pc + INSN_BYTES;
   wire [`XLEN-1:0]   pc_tgt   = iss.pc + iss.imm;
   wire [`XLEN-1:0]   jalr_sum = iss.opa + iss.imm;
   wire               is_jal   = iss.op == rv_slice_pkg::JAL;
   wire               is_jalr  = iss.op == rv_slice_pkg::JALR;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         iss.ack <= 1'b0;
         wb.req  <= 1'b0;
         full    <= 1'b0;
      end
      else
      begin
         if (take)
            iss.ack <= 1'b1;
         else if (!iss.req)
            iss.ack <= 1'b0;

         if (take)
            full <= 1'b1;
         else if (wb.req && wb.ack)
            full <= 1'b0;

         if (wb.req && wb.ack)
            wb.req <= 1'b0;
         else if (full && !wb.ack)
            wb.req <= 1'b1;
      end
   end

   always_comb
   begin
      alu     = '0;
      wres    = '0;
      word_op = 1'b0;
      case (iss.op)
         rv_slice_pkg::ADD:  alu = a + b;
         rv_slice_pkg::SUB:  alu = a - b;
         rv_slice_pkg::SLL:  alu = a << b[SH_W-1:0];
         rv_slice_pkg::SLT:  alu = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         rv_slice_pkg::SLTU: alu = {{(`XLEN-1){1'b0}}, a < b};
         rv_slice_pkg::XOR:  alu = a ^ b;
         rv_slice_pkg::SRL:  alu = a >> b[SH_W-1:0];
         rv_slice_pkg::SRA:  alu = $signed(a) >>> b[SH_W-1:0];
         rv_slice_pkg::OR:   alu = a | b;
         rv_slice_pkg::AND:  alu = a & b;
         rv_slice_pkg::ADDW:
         begin
            wres    = w_a + w_b;
            word_op = 1'b1;
         end
         rv_slice_pkg::SUBW:
         begin
            wres    = w_a - w_b;
            word_op = 1'b1;
         end
         rv_slice_pkg::SLLW:
         begin
            wres    = w_a << w_b[WSH_W-1:0];
            word_op = 1'b1;
         end
         rv_slice_pkg::SRLW:
         begin
            wres    = w_a >> w_b[WSH_W-1:0];
            word_op = 1'b1;
         end
         rv_slice_pkg::SRAW:
         begin
            wres    = $signed(w_a) >>> w_b[WSH_W-1:0];
            word_op = 1'b1;
         end
         rv_slice_pkg::JAL,
         rv_slice_pkg::JALR:   alu = link;
         rv_slice_pkg::PASS_B: alu = b;
         default: ; // branches and illegal leave zero
      endcase
      if (word_op)
         alu = {{(`XLEN-`WORD_W){wres[`WORD_W-1]}}, wres};
   end

   always_comb
   begin
      case (iss.op)
         rv_slice_pkg::BEQ:  cond = a == b;
         rv_slice_pkg::BNE:  cond = a != b;
         rv_slice_pkg::BLT:  cond = $signed(a) < $signed(b);
         rv_slice_pkg::BGE:  cond = $signed(a) >= $signed(b);
         rv_slice_pkg::BLTU: cond = a < b;
         rv_slice_pkg::BGEU: cond = a >= b;
         default:            cond = 1'b0;
      endcase
   end

   always_comb
   begin
      if (cond || is_jal)
         npc = pc_tgt;
      else if (is_jalr)
         npc = {jalr_sum[`XLEN-1:1], 1'b0};
      else
         npc = link;
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         wb.rd       <= iss.rd;
         wb.rd_we    <= iss.rd_we;
         wb.rd_val   <= alu;
         wb.br_taken <= cond | is_jal | is_jalr; // jumps count as taken
         wb.next_pc  <= npc;
         wb.illegal  <= iss.op == rv_slice_pkg::ILLEGAL;
      end
   end

endmodule

/* hw/writeback_stage.sv */
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module writeback_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   wb_if.wb_mp                    wb,
   output logic                   out_req,
   input  logic                   out_ack,
   output logic [`REG_IDX_W-1:0]  rd,
   output logic                   rd_we,
   output logic [`XLEN-1:0]       rd_val,
   output logic                   br_taken,
   output logic [`XLEN-1:0]       next_pc,
   output logic                   illegal
);

   logic full;

   wire take = wb.req & ~wb.ack & ~full;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wb.ack  <= 1'b0;
         out_req <= 1'b0;
         full    <= 1'b0;
      end
      else
      begin
         if (take)
            wb.ack <= 1'b1;
         else if (!wb.req)
            wb.ack <= 1'b0;

         // slot stays busy until the consumer acks
         if (take)
            full <= 1'b1;
         else if (out_req && out_ack)
            full <= 1'b0;

         if (out_req && out_ack)
            out_req <= 1'b0;
         else if (full && !out_ack)
            out_req <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         rd       <= wb.rd;
         rd_we    <= wb.rd_we;
         rd_val   <= wb.rd_val;
         br_taken <= wb.br_taken;
         next_pc  <= wb.next_pc;
         illegal  <= wb.illegal;
      end
   end

endmodule

/* hw/rv_slice_top.sv */
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module rv_slice_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_req,
   output logic                   in_ack,
   input  logic [`INSN_W-1:0]     insn,
   input  logic [`XLEN-1:0]       pc,
   input  logic [`XLEN-1:0]       rs1_val,
   input  logic [`XLEN-1:0]       rs2_val,
   output logic                   out_req,
   input  logic                   out_ack,
   output logic [`REG_IDX_W-1:0]  rd,
   output logic                   rd_we,
   output logic [`XLEN-1:0]       rd_val,
   output logic                   br_taken,
   output logic [`XLEN-1:0]       next_pc,
   output logic                   illegal
);

   issue_if iss_link ();
   wb_if    wb_link ();

   insn_decode u_decode (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_req  (in_req),
      .in_ack  (in_ack),
      .insn    (insn),
      .pc      (pc),
      .rs1_val (rs1_val),
      .rs2_val (rs2_val),
      .iss     (iss_link.decode_mp)
   );

   int_execute u_execute (
      .clk   (clk),
      .rst_n (rst_n),
      .iss   (iss_link.exec_mp),
      .wb    (wb_link.exec_mp)
   );

   // result slot facing the consumer
   writeback_stage u_writeback (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb       (wb_link.wb_mp),
      .out_req  (out_req),
      .out_ack  (out_ack),
      .rd       (rd),
      .rd_we    (rd_we),
      .rd_val   (rd_val),
      .br_taken (br_taken),
      .next_pc  (next_pc),
      .illegal  (illegal)
   );

endmodule

/* test/tb_rv_slice.sv */
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module tb_rv_slice;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_INSN   = 400; // instructions budgeted by the watchdog

   typedef struct packed {
      logic [`REG_IDX_W-1:0] rd;
      logic                  rd_we;
      logic [`XLEN-1:0]      rd_val;
      logic                  br_taken;
      logic [`XLEN-1:0]      next_pc;
      logic                  illegal;
   } result_t;

   logic                  clk;
   logic                  rst_n;
   logic                  in_req;
   logic                  in_ack;
   logic [`INSN_W-1:0]    insn;
   logic [`XLEN-1:0]      pc;
   logic [`XLEN-1:0]      rs1_val;
   logic [`XLEN-1:0]      rs2_val;
   logic                  out_req;
   logic                  out_ack;
   logic [`REG_IDX_W-1:0] rd;
   logic                  rd_we;
   logic [`XLEN-1:0]      rd_val;
   logic                  br_taken;
   logic [`XLEN-1:0]      next_pc;
   logic                  illegal;

   integer  seed;
   int      errors = 0;
   int      checks = 0;
   logic    hold;              // consumer withholds out_ack while set
   int      delays [0:511];
   result_t exp_q [$];
   string   name_q [$];

   rv_slice_top DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_req   (in_req),
      .in_ack   (in_ack),
      .insn     (insn),
      .pc       (pc),
      .rs1_val  (rs1_val),
      .rs2_val  (rs2_val),
      .out_req  (out_req),
      .out_ack  (out_ack),
      .rd       (rd),
      .rd_we    (rd_we),
      .rd_val   (rd_val),
      .br_taken (br_taken),
      .next_pc  (next_pc),
      .illegal  (illegal)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // expected result straight from the RV64I rules
   function automatic result_t model(input logic [31:0] i, input logic [`XLEN-1:0] p,
                                     input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
      result_t          r;
      logic [`XLEN-1:0] ii;
      logic [`XLEN-1:0] iu;
      logic [`XLEN-1:0] ib;
      logic [`XLEN-1:0] ij;
      logic [`XLEN-1:0] ob;
      logic [`XLEN-1:0] v;
      logic [31:0]      w;
      logic [6:0]       top;
      logic             imm_form;
      logic             ok;
      logic             wr;
      logic             taken;
      ii = {{52{i[31]}}, i[31:20]};
      iu = {{32{i[31]}}, i[31:12], 12'd0};
      ib = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      ij = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      r = '0;
      v = '0;
      w = '0;
      ok = 1'b1;
      wr = 1'b1;
      taken = 1'b0;
      imm_form = i[6:0] == rv_slice_pkg::OPC_OP_IMM || i[6:0] == rv_slice_pkg::OPC_OP_IMM_32;
      ob = imm_form ? ii : b;
      // 64-bit immediate shifts carry shamt[5] in bit 25
      top = (i[6:0] == rv_slice_pkg::OPC_OP_IMM) ? {i[31:26], 1'b0} : i[31:25];
      r.next_pc = p + 64'd4;
      case (i[6:0])
         rv_slice_pkg::OPC_OP, rv_slice_pkg::OPC_OP_IMM:
         begin
            ok = imm_form || top == 7'h00;
            case (i[14:12])
               3'd0:
               begin
                  v  = (!imm_form && top == 7'h20) ? a - ob : a + ob;
                  ok = imm_form || top == 7'h00 || top == 7'h20;
               end
               3'd1:
               begin
                  v  = a << ob[5:0];
                  ok = top == 7'h00;
               end
               3'd2: v = {63'd0, $signed(a) < $signed(ob)};
               3'd3: v = {63'd0, a < ob};
               3'd4: v = a ^ ob;
               3'd5:
               begin
                  if (top == 7'h20)
                     v = $signed(a) >>> ob[5:0];
                  else
                     v = a >> ob[5:0];
                  ok = top == 7'h00 || top == 7'h20;
               end
               3'd6: v = a | ob;
               default: v = a & ob;
            endcase
         end
         rv_slice_pkg::OPC_OP_32, rv_slice_pkg::OPC_OP_IMM_32:
         begin
            case (i[14:12])
               3'd0:
               begin
                  w  = (!imm_form && top == 7'h20) ? a[31:0] - ob[31:0] : a[31:0] + ob[31:0];
                  ok = imm_form || top == 7'h00 || top == 7'h20;
               end
               3'd1:
               begin
                  w  = a[31:0] << ob[4:0];
                  ok = top == 7'h00;
               end
               3'd5:
               begin
                  if (top == 7'h20)
                     w = $signed(a[31:0]) >>> ob[4:0];
                  else
                     w = a[31:0] >> ob[4:0];
                  ok = top == 7'h00 || top == 7'h20;
               end
               default: ok = 1'b0;
            endcase
            v = {{32{w[31]}}, w};
         end
         rv_slice_pkg::OPC_LUI:   v = iu;
         rv_slice_pkg::OPC_AUIPC: v = p + iu;
         rv_slice_pkg::OPC_BRANCH:
         begin
            wr = 1'b0;
            case (i[14:12])
               3'd0: taken = a == b;
               3'd1: taken = a != b;
               3'd4: taken = $signed(a) < $signed(b);
               3'd5: taken = $signed(a) >= $signed(b);
               3'd6: taken = a < b;
               3'd7: taken = a >= b;
               default: ok = 1'b0;
            endcase
            if (taken)
               r.next_pc = p + ib;
         end
         rv_slice_pkg::OPC_JAL:
         begin
            v = p + 64'd4;
            taken = 1'b1;
            r.next_pc = p + ij;
         end
         rv_slice_pkg::OPC_JALR:
         begin
            ok = i[14:12] == 3'd0;
            v = p + 64'd4;
            taken = 1'b1;
            r.next_pc = (a + ii) & ~64'd1;
         end
         default: ok = 1'b0;
      endcase
      if (!ok)
      begin
         v = '0;
         taken = 1'b0;
         r.next_pc = p + 64'd4;
      end
      r.rd       = i[11:7];
      r.rd_we    = wr && ok && i[11:7] != 5'd0;
      r.rd_val   = v;
      r.br_taken = taken;
      r.illegal  = !ok;
      return r;
   endfunction

   // kind picks the instruction class, r fills the remaining fields
   function automatic logic [31:0] build(input int kind, input logic [31:0] r);
      logic [31:0] i;
      i = r;
      case (kind)
         0:
         begin
            i[6:0]   = rv_slice_pkg::OPC_OP;
            i[31:25] = ((i[14:12] == 3'd0 || i[14:12] == 3'd5) && r[30]) ? 7'h20 : 7'h00;
         end
         1:
         begin
            i[6:0] = rv_slice_pkg::OPC_OP_IMM;
            if (i[14:12] == 3'd1)
               i[31:26] = 6'h00;
            if (i[14:12] == 3'd5)
               i[31:26] = r[30] ? 6'h10 : 6'h00;
         end
         2: i[6:0] = rv_slice_pkg::OPC_LUI;
         3: i[6:0] = rv_slice_pkg::OPC_AUIPC;
         4, 5:
         begin
            i[6:0] = (kind == 4) ? rv_slice_pkg::OPC_OP_32 : rv_slice_pkg::OPC_OP_IMM_32;
            case (r[13:12])
               2'b00:   i[14:12] = 3'd0;
               2'b01:   i[14:12] = 3'd1;
               default: i[14:12] = 3'd5;
            endcase
            if (kind == 4 || i[14:12] != 3'd0)
               i[31:25] = (i[14:12] != 3'd1 && r[30]) ? 7'h20 : 7'h00;
         end
         6:
         begin
            i[6:0] = rv_slice_pkg::OPC_BRANCH;
            if (i[14:13] == 2'b01)
               i[14] = 1'b1; // no branch with funct3 2 or 3
         end
         7: i[6:0] = rv_slice_pkg::OPC_JAL;
         8:
         begin
            i[6:0]   = rv_slice_pkg::OPC_JALR;
            i[14:12] = 3'd0;
         end
         default:
         begin
            case (r[9:8])
               2'b00: i[6:0] = 7'h03; // load
               2'b01: i[6:0] = 7'h73; // system
               2'b10:
               begin
                  i[6:0]   = rv_slice_pkg::OPC_OP;
                  i[31:25] = 7'h01; // M extension
               end
               default:
               begin
                  i[6:0]   = rv_slice_pkg::OPC_BRANCH;
                  i[14:12] = 3'd2;
               end
            endcase
         end
      endcase
      return i;
   endfunction

   task automatic mismatch(input string test, input string field,
                           input logic [63:0] exp, input logic [63:0] act);
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", test, field, exp, act);
   endtask

   task automatic compare(input string test, input result_t e);
      checks++;
      assert (rd === e.rd) else mismatch(test, "rd", 64'(e.rd), 64'(rd));
      assert (rd_we === e.rd_we) else mismatch(test, "rd_we", 64'(e.rd_we), 64'(rd_we));
      if (e.rd_we)
         assert (rd_val === e.rd_val) else mismatch(test, "rd_val", e.rd_val, rd_val);
      assert (br_taken === e.br_taken)
         else mismatch(test, "br_taken", 64'(e.br_taken), 64'(br_taken));
      assert (next_pc === e.next_pc) else mismatch(test, "next_pc", e.next_pc, next_pc);
      assert (illegal === e.illegal)
         else mismatch(test, "illegal", 64'(e.illegal), 64'(illegal));
   endtask

   // four-phase producer side
   task automatic issue(input string test, input logic [31:0] i, input logic [`XLEN-1:0] p,
                        input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
      @(negedge clk);
      insn    = i;
      pc      = p;
      rs1_val = a;
      rs2_val = b;
      in_req  = 1'b1;
      exp_q.push_back(model(i, p, a, b));
      name_q.push_back(test);
      @(negedge clk);
      while (!in_ack)
         @(negedge clk);
      in_req = 1'b0;
      @(negedge clk);
      while (in_ack)
         @(negedge clk);
   endtask

   task automatic run_random(input string test, input int first, input int last,
                             input int count);
      logic [31:0]      r;
      logic [31:0]      i;
      logic [`XLEN-1:0] p;
      logic [`XLEN-1:0] a;
      logic [`XLEN-1:0] b;
      int               kind;
      int               k;
      for (k = 0; k < count; k++)
      begin
         kind = first + k % (last - first + 1);
         r = $random(seed);
         i = build(kind, r);
         if (k % 7 == 3)
            i[11:7] = 5'd0; // x0 destination
         p = {$random(seed), $random(seed)};
         p[1:0] = 2'b00;
         a = {$random(seed), $random(seed)};
         b = {$random(seed), $random(seed)};
         if (kind == 6 && r[1])
            b = a; // equal operands for beq/bge paths
         issue(test, i, p, a, b);
      end
   endtask

   initial
   begin : consumer
      result_t e;
      string   test;
      int      seen;
      seen = 0;
      out_ack = 1'b0;
      forever
      begin
         @(negedge clk);
         if (out_req === 1'b1)
         begin
            if (exp_q.size() == 0)
            begin
               errors++;
               $display("a result came out with no instruction outstanding");
            end
            else
            begin
               e = exp_q.pop_front();
               test = name_q.pop_front();
               compare(test, e);
            end
            repeat (delays[seen % 512])
               @(negedge clk);
            seen++;
            while (hold)
               @(negedge clk);
            out_ack = 1'b1;
            while (out_req)
               @(negedge clk);
            out_ack = 1'b0;
         end
      end
   end

   initial
   begin : stimulus
      int n;
      seed = 32'h8945;
      for (n = 0; n < 512; n++)
         delays[n] = {$random(seed)} % 6;
      hold    = 1'b0;
      rst_n   = 1'b0;
      in_req  = 1'b0;
      insn    = '0;
      pc      = '0;
      rs1_val = '0;
      rs2_val = '0;
      repeat (10)
         @(negedge clk);
      assert (in_ack === 1'b0 && out_req === 1'b0) else
      begin
         errors++;
         $display("in_ack or out_req is not low after reset");
      end
      rst_n = 1'b1;

      run_random("alu_rr", 0, 0, 60);
      run_random("alu_imm", 1, 3, 60);
      run_random("word", 4, 5, 60);
      run_random("branch_jump", 6, 8, 60);
      run_random("illegal", 9, 9, 20);
      run_random("mixed", 0, 9, 100);

      // fill all three stages while the consumer stalls
      while (exp_q.size() != 0 || out_req || out_ack)
         @(negedge clk);
      hold = 1'b1;
      run_random("backpressure", 0, 9, 3);
      fork
         issue("backpressure", 32'h06400293, 64'h1000, 64'd0, 64'd0); // addi x5, x0, 100
         begin
            repeat (30)
            begin
               @(negedge clk);
               checks++;
               assert (!in_ack) else
               begin
                  errors++;
                  $display("decode accepted a fourth instruction while the pipeline was full");
               end
            end
            hold = 1'b0;
         end
      join

      while (exp_q.size() != 0 || out_req)
         @(negedge clk);
      repeat (5)
         @(negedge clk);
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   initial
   begin : watchdog
      #(NUM_INSN * 40 * CLK_PERIOD);
      $display("timeout: the DUT stopped handing back results before the run finished");
      $display("checks: %0d  errors: %0d", checks, errors);
      $display("test failed");
      $finish;
   end

endmodule

/* src.f */
+incdir+hw
hw/rv_slice_pkg.sv
hw/issue_if.sv
hw/wb_if.sv
hw/insn_decode.sv
hw/int_execute.sv
hw/writeback_stage.sv
hw/rv_slice_top.sv
test/tb_rv_slice.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_rv_slice -f src.f -o tb_rv_slice
output=$(./obj_dir/tb_rv_slice)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
   exit 0
fi
exit 1
